/* mem_pkg.sv */
// Register-file subsystem package: widths, word types, request structs and power FSM states
`default_nettype none

package mem_pkg;

    // ----------------------------------------------------------
    // Array geometry
    // ----------------------------------------------------------

    // Number of entries in the register file
    localparam int RF_DEPTH = 64;
    // Address width, enough for RF_DEPTH entries
    localparam int RF_ADDR_W = 6;
    // Logical word seen by the requester
    localparam int RF_DATA_W = 31;
    // Physical word of the array macro, one bit wider than needed
    localparam int RF_PHYS_W = 32;

    // ----------------------------------------------------------
    // Timing
    // ----------------------------------------------------------

    // Stages in the power-enable daisy chain across the array segments
    localparam int PWR_CHAIN_DEPTH = 4;
    // Flops in the reset synchronizer
    localparam int RST_SYNC_STAGES = 2;

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [RF_DATA_W-1:0] rf_data_t;
    typedef logic [RF_PHYS_W-1:0] rf_phys_t;

    // Write port request, valid for one wclk cycle while we is high
    typedef struct packed {
        logic     we;
        rf_addr_t waddr;
        rf_data_t wdata;
    } rf_wr_req_t;

    // Read port request, sampled at the rclk edge where re is high
    typedef struct packed {
        logic     re;
        rf_addr_t raddr;
    } rf_rd_req_t;

    // Power controls, both active high for "off" or "isolated"
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } rf_pwr_t;

    // Power-gating sequencer states
    typedef enum logic [2:0] {
        PWR_RESET,
        PWR_ON_WAIT,
        PWR_RELEASE,
        PWR_READY,
        PWR_ISOLATE,
        PWR_OFF_WAIT,
        PWR_OFF
    } pwr_state_t;

endpackage

`default_nettype wire

/* mem_pwr_ctrl.sv */
// Power-gating sequencer: orders isolation and supply enable, and reports array readiness
`timescale 1ns/10ps
`default_nettype none

module mem_pwr_ctrl (
     input  logic              clk
    ,input  logic              rst_n
    ,input  logic              sleep_req
    ,input  logic              pwr_ack_b
    ,output mem_pkg::rf_pwr_t  pwr
    ,output logic              mem_ready
);

    mem_pkg::pwr_state_t state_q;
    mem_pkg::pwr_state_t state_d;

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------

    // Power-on goes supply first, then isolation release
    // Power-off goes isolation first, then supply removal
    // Both directions wait on the chain tail instead of a fixed count
    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::PWR_RESET: begin
                state_d = mem_pkg::PWR_ON_WAIT;
            end
            mem_pkg::PWR_ON_WAIT: begin
                // Tail low means every segment is powered
                if (!pwr_ack_b) begin
                    state_d = mem_pkg::PWR_RELEASE;
                end
            end
            mem_pkg::PWR_RELEASE: begin
                state_d = mem_pkg::PWR_READY;
            end
            mem_pkg::PWR_READY: begin
                if (sleep_req) begin
                    state_d = mem_pkg::PWR_ISOLATE;
                end
            end
            mem_pkg::PWR_ISOLATE: begin
                state_d = mem_pkg::PWR_OFF_WAIT;
            end
            mem_pkg::PWR_OFF_WAIT: begin
                // Tail high means the last segment has dropped its supply
                if (pwr_ack_b) begin
                    state_d = mem_pkg::PWR_OFF;
                end
            end
            mem_pkg::PWR_OFF: begin
                if (!sleep_req) begin
                    state_d = mem_pkg::PWR_ON_WAIT;
                end
            end
            default: begin
                state_d = mem_pkg::PWR_RESET;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mem_pkg::PWR_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------

    // Decoded from the state register only, so each control changes once per edge
    // Isolation is open only in RELEASE and READY, where the supply is surely on
    always_comb begin
        pwr.isol_en      = 1'b1;
        pwr.pwr_enable_b = 1'b0;
        mem_ready        = 1'b0;
        case (state_q)
            mem_pkg::PWR_RELEASE: begin
                pwr.isol_en = 1'b0;
            end
            mem_pkg::PWR_READY: begin
                pwr.isol_en = 1'b0;
                mem_ready   = 1'b1;
            end
            mem_pkg::PWR_RESET, mem_pkg::PWR_OFF_WAIT, mem_pkg::PWR_OFF: begin
                pwr.pwr_enable_b = 1'b1;
            end
            default: begin
                pwr.pwr_enable_b = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* mem_reset_sync.sv */
// Reset synchronizer with asynchronous assertion, synchronous release and scan bypass
`timescale 1ns/10ps
`default_nettype none

module mem_reset_sync (
     input  logic clk
    ,input  logic rst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // ----------------------------------------------------------
    // Synchronizer chain
    // ----------------------------------------------------------

    // Shift register of ones that empties immediately on reset
    logic [mem_pkg::RST_SYNC_STAGES-1:0] sync_q;

    // The chain clears as soon as rst_n falls, no clock needed
    // On release a one walks in, so the output rises after RST_SYNC_STAGES edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[mem_pkg::RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // ----------------------------------------------------------
    // Scan bypass
    // ----------------------------------------------------------

    // In scan mode the tester owns the reset directly
    // Otherwise the last flop of the chain is the clean reset
    always_comb begin
        if (fscan_rstbypen) begin
            rst_n_sync = fscan_byprst_b;
        end else begin
            rst_n_sync = sync_q[mem_pkg::RST_SYNC_STAGES-1];
        end
    end

endmodule

`default_nettype wire

/* mem_rf_array_64x32.sv */
// Behavioral two-port 64x32 register-file array with power chain, isolation and content loss
`timescale 1ns/10ps
`default_nettype none

module mem_rf_array_64x32 (
     input  logic               wclk
    ,input  logic               wr_en
    ,input  mem_pkg::rf_addr_t  wr_addr
    ,input  mem_pkg::rf_phys_t  wr_data

    ,input  logic               rclk
    ,input  logic               rd_en
    ,input  mem_pkg::rf_addr_t  rd_addr
    ,output mem_pkg::rf_phys_t  rd_data

    ,input  logic               ip_reset_b
    ,input  logic               isol_en
    ,input  logic               pwr_mgmt_in
    ,output logic               pwr_mgmt_out
);

    // Power chain, one flop per array segment, all high means fully off
    logic [mem_pkg::PWR_CHAIN_DEPTH-1:0] pwr_chain_q;
    // Array is usable only when every segment has its supply enabled
    logic                                array_on;
    logic                                wr_ok;
    logic [mem_pkg::RF_DEPTH-1:0]        valid_q;
    mem_pkg::rf_phys_t                   mem_q [mem_pkg::RF_DEPTH];
    mem_pkg::rf_phys_t                   rd_word;
    mem_pkg::rf_phys_t                   rd_q;

    // ----------------------------------------------------------
    // Power-enable daisy chain
    // ----------------------------------------------------------

    // The enable ripples one segment per rclk, so wake and sleep both take
    // PWR_CHAIN_DEPTH cycles to reach the tail
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            pwr_chain_q <= '1;
        end else begin
            pwr_chain_q <= {pwr_chain_q[mem_pkg::PWR_CHAIN_DEPTH-2:0], pwr_mgmt_in};
        end
    end

    assign pwr_mgmt_out = pwr_chain_q[mem_pkg::PWR_CHAIN_DEPTH-1];
    // The first segment to switch off already makes the array unusable
    assign array_on     = ~|pwr_chain_q;

    // ----------------------------------------------------------
    // Write port
    // ----------------------------------------------------------

    // Writes need supply and an open isolation boundary
    assign wr_ok = wr_en & array_on & ~isol_en;

    always_ff @(posedge wclk) begin
        if (wr_ok) begin
            mem_q[wr_addr] <= wr_data;
        end
    end

    // Valid bits model content loss: any time the supply is gone they clear,
    // so a word only reads back if it was written since the last power-up
    // The array_on level comes from the rclk side and is treated as quasi-static here
    always_ff @(posedge wclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            valid_q <= '0;
        end else if (!array_on) begin
            valid_q <= '0;
        end else if (wr_ok) begin
            valid_q[wr_addr] <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Read port
    // ----------------------------------------------------------

    // Unwritten, unpowered or isolated reads capture zero
    assign rd_word = (array_on && !isol_en && valid_q[rd_addr]) ? mem_q[rd_addr] : '0;

    // Registered output, updated only by a read and held until the next one
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            rd_q <= '0;
        end else if (rd_en) begin
            rd_q <= rd_word;
        end
    end

    // Isolation clamps the output at the boundary
    assign rd_data = isol_en ? '0 : rd_q;

endmodule

`default_nettype wire

/* mem_rf_pg_64x31.sv */
// Power-gated 64x31 register-file wrapper around the 64x32 physical array
`timescale 1ns/10ps
`default_nettype none

module mem_rf_pg_64x31 (
     input  logic                 wclk
    ,input  logic                 rclk

    ,input  mem_pkg::rf_wr_req_t  wr
    ,input  mem_pkg::rf_rd_req_t  rd
    ,output mem_pkg::rf_data_t    rdata

    // Power interface
    ,input  mem_pkg::rf_pwr_t     pwr
    ,output logic                 pwr_enable_b_out

    ,input  logic                 ip_reset_b

    ,input  logic                 fscan_rstbypen
    ,input  logic                 fscan_byprst_b
);

    // Array reset after synchronization into the read clock domain
    logic              ip_reset_b_sync;
    // Full physical word on both sides of the array
    mem_pkg::rf_phys_t wr_phys;
    mem_pkg::rf_phys_t rd_phys;

    // ----------------------------------------------------------
    // Array reset
    // ----------------------------------------------------------

    // The power chain and read register live on rclk, so the reset is released there
    mem_reset_sync u_ip_reset_sync (
         .clk            (rclk)
        ,.rst_n          (ip_reset_b)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (ip_reset_b_sync)
    );

    // ----------------------------------------------------------
    // Physical array
    // ----------------------------------------------------------

    // Spare top bit is written as zero
    assign wr_phys = {1'b0, wr.wdata};

    mem_rf_array_64x32 u_array (
         .wclk         (wclk)
        ,.wr_en        (wr.we)
        ,.wr_addr      (wr.waddr)
        ,.wr_data      (wr_phys)

        ,.rclk         (rclk)
        ,.rd_en        (rd.re)
        ,.rd_addr      (rd.raddr)
        ,.rd_data      (rd_phys)

        ,.ip_reset_b   (ip_reset_b_sync)
        ,.isol_en      (pwr.isol_en)
        ,.pwr_mgmt_in  (pwr.pwr_enable_b)
        ,.pwr_mgmt_out (pwr_enable_b_out)
    );

    // Only the logical 31 bits leave the wrapper
    assign rdata = rd_phys[mem_pkg::RF_DATA_W-1:0];

endmodule

`default_nettype wire

/* mem_subsys_checker.sv */
// Power and isolation rule assertions, bound into the 64x31 wrapper
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_checker (
     input  logic                 rclk
    ,input  logic                 rst_n
    ,input  mem_pkg::rf_pwr_t     pwr
    ,input  mem_pkg::rf_rd_req_t  rd
    ,input  mem_pkg::rf_data_t    rdata
    ,input  logic                 mem_ready
);

    // Supply removal is only safe behind a closed isolation boundary
    a_off_needs_isol: assert property (@(posedge rclk) disable iff (!rst_n)
        pwr.pwr_enable_b |-> pwr.isol_en)
        else $error("supply disabled while isolation is open");

    // A read issued under isolation must hand back zero on the next cycle
    a_isol_read_zero: assert property (@(posedge rclk) disable iff (!rst_n)
        (rd.re && pwr.isol_en) |=> (rdata == '0))
        else $error("read under isolation returned a nonzero word");

    // The requester is never told ready while the array is fenced off
    a_ready_not_isol: assert property (@(posedge rclk) disable iff (!rst_n)
        !(mem_ready && pwr.isol_en))
        else $error("mem_ready high while isolation is on");

endmodule

`default_nettype wire

/* mem_subsys_stim.txt */
# op addr data, all hex: W writes data, R reads and expects data
# S sleeps, K wakes, X runs the LFSR sweep; S, K and X ignore addr and data
R 00 00000000
R 3f 00000000
W 00 12345678
W 3f 7fffffff
W 15 2aaaaaaa
W 2a 55555555
R 00 12345678
R 3f 7fffffff
R 15 2aaaaaaa
R 2a 55555555
W 15 00000001
R 15 00000001
X 00 00000000
S 00 00000000
R 15 00000000
W 07 0badf00d
R 07 00000000
K 00 00000000
R 07 00000000
R 15 00000000
R 3f 00000000
W 07 7ace0ace
R 07 7ace0ace
W 08 1dead001
R 08 1dead001

/* mem_subsys_top.sv */
// Register-file subsystem top: power sequencer plus the power-gated 64x31 wrapper
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top (
     input  logic               wclk
    ,input  logic               rclk
    ,input  logic               rst_n

    ,input  logic               we
    ,input  mem_pkg::rf_addr_t  waddr
    ,input  mem_pkg::rf_data_t  wdata

    ,input  logic               re
    ,input  mem_pkg::rf_addr_t  raddr
    ,output mem_pkg::rf_data_t  rdata

    ,input  logic               sleep_req
    ,output logic               mem_ready

    ,input  logic               fscan_rstbypen
    ,input  logic               fscan_byprst_b
);

    mem_pkg::rf_wr_req_t wr_req;
    mem_pkg::rf_rd_req_t rd_req;
    mem_pkg::rf_pwr_t    pwr;
    // Chain tail, used by the sequencer as its power acknowledge
    logic                pwr_ack_b;

    // ----------------------------------------------------------
    // Request packing
    // ----------------------------------------------------------

    assign wr_req = '{we: we, waddr: waddr, wdata: wdata};
    assign rd_req = '{re: re, raddr: raddr};

    // The sequencer shares rclk with the power chain it watches
    mem_pwr_ctrl u_pwr_ctrl (
         .clk       (rclk)
        ,.rst_n     (rst_n)
        ,.sleep_req (sleep_req)
        ,.pwr_ack_b (pwr_ack_b)
        ,.pwr       (pwr)
        ,.mem_ready (mem_ready)
    );

    mem_rf_pg_64x31 u_rf (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.wr               (wr_req)
        ,.rd               (rd_req)
        ,.rdata            (rdata)
        ,.pwr              (pwr)
        ,.pwr_enable_b_out (pwr_ack_b)
        ,.ip_reset_b       (rst_n)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
verilator --binary --timing --assert --timescale 1ns/10ps -f tb.f \
    --top-module tb_mem_subsys -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep "Done: no errors" > /dev/null \
    && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb.f */
mem_pkg.sv
mem_reset_sync.sv
mem_rf_array_64x32.sv
mem_rf_pg_64x31.sv
mem_pwr_ctrl.sv
mem_subsys_top.sv
mem_subsys_checker.sv
tb_clock_gen.sv
tb_mem_subsys.sv

/* tb_clock_gen.sv */
// Testbench clock and reset source for the register-file subsystem
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
     output logic clk
    ,output logic rst_n
);

    // 100 ns period, shared by the write and read clocks
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset is held for five rising edges and released just after the fifth
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_mem_subsys.sv */
// Testbench for the register-file subsystem, driven from a stimulus file with a memory model
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;

    logic              clk;
    logic              rst_n;
    logic              we;
    mem_pkg::rf_addr_t waddr;
    mem_pkg::rf_data_t wdata;
    logic              re;
    mem_pkg::rf_addr_t raddr;
    mem_pkg::rf_data_t rdata;
    logic              sleep_req;
    logic              mem_ready;
    logic              fscan_rstbypen;
    logic              fscan_byprst_b;

    // Reference model with the contents and a valid bit per entry
    mem_pkg::rf_data_t            model_mem [mem_pkg::RF_DEPTH];
    logic [mem_pkg::RF_DEPTH-1:0] model_valid;
    logic                         asleep;
    logic                         aborted;
    logic [31:0]                  lfsr_q;
    int                           errors;
    int                           checks;
    int                           tests_run;
    int                           tests_failed;

    tb_clock_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    mem_subsys_top u_dut (
         .wclk (clk), .rclk (clk), .rst_n (rst_n)
        ,.we (we), .waddr (waddr), .wdata (wdata)
        ,.re (re), .raddr (raddr), .rdata (rdata)
        ,.sleep_req (sleep_req), .mem_ready (mem_ready)
        ,.fscan_rstbypen (fscan_rstbypen), .fscan_byprst_b (fscan_byprst_b)
    );

    bind mem_rf_pg_64x31 mem_subsys_checker u_checker (
         .rclk (rclk), .rst_n (ip_reset_b_sync), .pwr (pwr), .rd (rd), .rdata (rdata)
        ,.mem_ready (tb_mem_subsys.u_dut.mem_ready)
    );

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    // Every drive lands 10 ns after a rising edge
    task automatic tick;
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string what, input mem_pkg::rf_data_t got,
                               input mem_pkg::rf_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Polls mem_ready or the power chain tail and gives up after a bounded number of cycles
    task automatic wait_for(input bit on_chain, input logic level, input string what);
        int n;
        n = 0;
        while ((on_chain ? u_dut.u_rf.pwr_enable_b_out : mem_ready) !== level && !aborted) begin
            if (n >= mem_pkg::PWR_CHAIN_DEPTH * 10) begin
                $display("Timeout: %s did not reach %b within %0d cycles", what, level, n);
                aborted = 1'b1;
            end else begin
                tick();
                n++;
            end
        end
    endtask

    function automatic mem_pkg::rf_data_t model_read(input mem_pkg::rf_addr_t a);
        return model_valid[a] ? model_mem[a] : '0;
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output mem_pkg::rf_data_t w);
        for (int b = 0; b < mem_pkg::RF_DATA_W; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[b] = lfsr_q[0];
        end
    endtask

    task automatic write_word(input mem_pkg::rf_addr_t a, input mem_pkg::rf_data_t d);
        we    = 1'b1;
        waddr = a;
        wdata = d;
        tick();
        we = 1'b0;
        // A powered-down array drops the write, and so does the model
        if (!asleep) begin
            model_mem[a]   = d;
            model_valid[a] = 1'b1;
        end
    endtask

    // The word is sampled one rclk cycle after re, once the read register has loaded
    task automatic read_word(input mem_pkg::rf_addr_t a, output mem_pkg::rf_data_t d);
        re    = 1'b1;
        raddr = a;
        tick();
        re = 1'b0;
        d  = rdata;
    endtask

    // Back to back reads of every entry where each word is checked while the
    // next address is already out
    task automatic read_back_all(input string tag);
        re    = 1'b1;
        raddr = '0;
        for (int i = 1; i <= mem_pkg::RF_DEPTH; i++) begin
            tick();
            check_value($sformatf("%s %0d", tag, i - 1), rdata,
                        model_read(mem_pkg::rf_addr_t'(i - 1)));
            raddr = mem_pkg::rf_addr_t'(i);
        end
        re = 1'b0;
    endtask

    task automatic run_sweep;
        mem_pkg::rf_data_t w;
        for (int i = 0; i < mem_pkg::RF_DEPTH; i++) begin
            draw_word(w);
            write_word(mem_pkg::rf_addr_t'(i), w);
        end
        read_back_all("sweep read");
    endtask

    task automatic finish_test(input string desc, input int errs_before);
        tests_run++;
        if (errors != errs_before || aborted) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, desc,
                 (errors == errs_before && !aborted) ? "ok" : "FAILED");
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial begin
        string             line;
        int                fd;
        int                n;
        int                errs_before;
        logic [7:0]        op;
        logic [31:0]       addr_f;
        logic [31:0]       data_f;
        mem_pkg::rf_data_t got;
        we             = 1'b0;
        waddr          = '0;
        wdata          = '0;
        re             = 1'b0;
        raddr          = '0;
        sleep_req      = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        model_valid = '0;
        asleep  = 1'b0;
        aborted = 1'b0;
        lfsr_q  = 32'hdbc2_ed2c;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;

        // Reset is looked at on the rising edge, well away from its release
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        #10;
        if (rst_n !== 1'b1) begin
            $display("Reset was never released by the clock generator");
            aborted = 1'b1;
        end

        // Sequencer comes out of reset isolated and not ready
        errs_before = errors;
        check_value("mem_ready after reset", mem_pkg::rf_data_t'(mem_ready), '0);
        check_value("isolation after reset", mem_pkg::rf_data_t'(u_dut.pwr.isol_en), 1);
        wait_for(1'b0, 1'b1, "mem_ready");
        finish_test("reset and power-up", errs_before);

        fd = $fopen("mem_subsys_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file mem_subsys_stim.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) != 0) begin
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h", op, addr_f, data_f);
            errs_before = errors;
            case (op)
                "W": begin
                    write_word(addr_f[mem_pkg::RF_ADDR_W-1:0], data_f[mem_pkg::RF_DATA_W-1:0]);
                    finish_test($sformatf("write %h", addr_f[7:0]), errs_before);
                end
                "R": begin
                    read_word(addr_f[mem_pkg::RF_ADDR_W-1:0], got);
                    check_value($sformatf("read %h", addr_f[7:0]), got,
                                data_f[mem_pkg::RF_DATA_W-1:0]);
                    finish_test($sformatf("read %h", addr_f[7:0]), errs_before);
                end
                "S": begin
                    sleep_req = 1'b1;
                    wait_for(1'b0, 1'b0, "mem_ready");
                    wait_for(1'b1, 1'b1, "pwr_enable_b_out");
                    // Contents are gone once the chain has switched off
                    asleep      = 1'b1;
                    model_valid = '0;
                    finish_test("sleep", errs_before);
                end
                "K": begin
                    sleep_req = 1'b0;
                    wait_for(1'b0, 1'b1, "mem_ready");
                    asleep = 1'b0;
                    // Nothing survives the power cycle so every entry reads zero
                    if (!aborted) begin
                        read_back_all("wake read");
                    end
                    finish_test("wake", errs_before);
                end
                "X": begin
                    run_sweep();
                    finish_test("random sweep", errs_before);
                end
                default: begin
                    errors++;
                    $display("Unknown operation in stimulus line: %s", line);
                    finish_test("bad stimulus line", errs_before);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
